/* bus_decoder.sv */
/*
 * Request intake, address window decode, alignment check
 * and per-device request strobes
 */
`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module bus_decoder (
  input  logic                      clk_sys_i,
  input  logic                      rst_sys_ni,

  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  logic                      req_we_i,
  input  logic [`PERIPH_ADDR_W-1:0] req_addr_i,
  input  logic [`PERIPH_DATA_W-1:0] req_wdata_i,
  input  logic [`PERIPH_BE_W-1:0]   req_be_i,

  input  logic                      slot_free_i,
  output logic                      accept_o,
  output periph_pkg::dev_sel_e      sel_o,

  dev_bus_if.host                   ram_bus,
  dev_bus_if.host                   gpio_bus,
  dev_bus_if.host                   timer_bus
);

  logic hit_ram;
  logic hit_gpio;
  logic hit_timer;
  logic aligned;
  periph_pkg::bus_op_e op;

  assign hit_ram   = (req_addr_i & `RAM_MASK) == `RAM_BASE;
  assign hit_gpio  = (req_addr_i & `GPIO_MASK) == `GPIO_BASE;
  assign hit_timer = (req_addr_i & `TIMER_MASK) == `TIMER_BASE;
  assign aligned   = req_addr_i[1:0] == 2'b00;

  always_comb begin
    if (!aligned) begin
      sel_o = periph_pkg::DevNone;
    end else if (hit_ram) begin
      sel_o = periph_pkg::DevRam;
    end else if (hit_gpio) begin
      sel_o = periph_pkg::DevGpio;
    end else if (hit_timer) begin
      sel_o = periph_pkg::DevTimer;
    end else begin
      sel_o = periph_pkg::DevNone; // No window matched
    end
  end

  // Ready waits only on the response slot as there is one host
  assign req_ready_o = slot_free_i;
  assign accept_o    = req_valid_i & slot_free_i;

  assign op = req_we_i ? periph_pkg::OpWrite : periph_pkg::OpRead;

  assign ram_bus.req    = accept_o & (sel_o == periph_pkg::DevRam);
  assign ram_bus.op     = op;
  assign ram_bus.offset = req_addr_i[`DEV_OFS_W-1:0];
  assign ram_bus.be     = req_be_i;
  assign ram_bus.wdata  = req_wdata_i;

  assign gpio_bus.req    = accept_o & (sel_o == periph_pkg::DevGpio);
  assign gpio_bus.op     = op;
  assign gpio_bus.offset = req_addr_i[`DEV_OFS_W-1:0];
  assign gpio_bus.be     = req_be_i;
  assign gpio_bus.wdata  = req_wdata_i;

  assign timer_bus.req    = accept_o & (sel_o == periph_pkg::DevTimer);
  assign timer_bus.op     = op;
  assign timer_bus.offset = req_addr_i[`DEV_OFS_W-1:0];
  assign timer_bus.be     = req_be_i;
  assign timer_bus.wdata  = req_wdata_i;

  // Device windows never overlap, so at most one device owns a request
  a_win_onehot: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    req_valid_i |-> $onehot0({hit_ram, hit_gpio, hit_timer}));

  // Stalled request keeps its fields
  a_req_held: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    req_valid_i && !req_ready_o |=>
      req_valid_i && $stable(req_we_i) && $stable(req_addr_i) &&
      $stable(req_be_i) && $stable(req_wdata_i));

endmodule

`default_nettype wire

/* dev_bus_if.sv */
/*
 * Per-device request and read data interface, host and device modports
 */
`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

interface dev_bus_if;

  logic                      req;    // One-cycle strobe
  periph_pkg::bus_op_e       op;
  logic [`DEV_OFS_W-1:0]     offset; // Byte offset within the window, word aligned
  logic [`PERIPH_BE_W-1:0]   be;
  logic [`PERIPH_DATA_W-1:0] wdata;
  logic [`PERIPH_DATA_W-1:0] rdata;  // Held until the next read

  modport host (
    output req,
    output op,
    output offset,
    output be,
    output wdata,
    input  rdata
  );

  modport device (
    input  req,
    input  op,
    input  offset,
    input  be,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

/* gpio_dev.sv */
/*
 * GPIO: byte-writable output register and two-flop synchronized input
 */
`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module gpio_dev (
  input  logic              clk_sys_i,
  input  logic              rst_sys_ni,
  dev_bus_if.device         bus,
  input  logic [`GPI_W-1:0] gp_i,
  output logic [`GPO_W-1:0] gp_o
);

  logic [`GPO_W-1:0] gpo_q;
  logic [`GPI_W-1:0] gpi_meta_q; // First sync stage
  logic [`GPI_W-1:0] gpi_q;
  logic              wr_out;

  assign wr_out = bus.req && (bus.op == periph_pkg::OpWrite) && (bus.offset == `GPIO_OUT_OFS);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpo_q      <= '0;
      gpi_meta_q <= '0;
      gpi_q      <= '0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_q      <= gpi_meta_q;
      if (wr_out) begin
        for (int b = 0; b < `GPO_W / 8; b++) begin
          if (bus.be[b]) begin
            gpo_q[8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  assign gp_o = gpo_q;

  always_ff @(posedge clk_sys_i) begin
    if (bus.req && (bus.op == periph_pkg::OpRead)) begin
      case (bus.offset)
        `GPIO_OUT_OFS: bus.rdata <= `PERIPH_DATA_W'(gpo_q);
        `GPIO_IN_OFS:  bus.rdata <= `PERIPH_DATA_W'(gpi_q);
        default:       bus.rdata <= '0; // Unused offsets read zero
      endcase
    end
  end

endmodule

`default_nettype wire

/* periph_macros.svh */
/*
 * Address map, register offsets and bus widths of the peripheral subsystem
 */
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

`define PERIPH_ADDR_W 32
`define PERIPH_DATA_W 32
`define PERIPH_BE_W   4

// Device windows, 4 KiB each
`define RAM_BASE   32'h0010_0000
`define RAM_MASK   32'hFFFF_F000
`define RAM_WORDS  1024
`define GPIO_BASE  32'h8000_0000
`define GPIO_MASK  32'hFFFF_F000
`define TIMER_BASE 32'h8000_2000
`define TIMER_MASK 32'hFFFF_F000

`define DEV_OFS_W 12 // In-window byte offset

`define GPIO_OUT_OFS      12'h000
`define GPIO_IN_OFS       12'h004
`define TIMER_TIME_LO_OFS 12'h000
`define TIMER_TIME_HI_OFS 12'h004
`define TIMER_CMP_LO_OFS  12'h008
`define TIMER_CMP_HI_OFS  12'h00C

`define GPI_W 8
`define GPO_W 16

`endif

/* periph_pkg.sv */
/*
 * Shared types: device select and bus operation enums
 */
`default_nettype none

package periph_pkg;

  // Owner of an access, DevNone for unmapped or misaligned
  typedef enum logic [1:0] {
    DevRam,
    DevGpio,
    DevTimer,
    DevNone
  } dev_sel_e;

  typedef enum logic {
    OpRead,
    OpWrite
  } bus_op_e;

endpackage

`default_nettype wire

/* periph_top.sv */
/*
 * Peripheral subsystem top: decoder, RAM, GPIO, timer and response slot
 */
`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module periph_top (
  input  logic                      clk_sys_i,
  input  logic                      rst_sys_ni,

  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  logic                      req_we_i,
  input  logic [`PERIPH_ADDR_W-1:0] req_addr_i,
  input  logic [`PERIPH_BE_W-1:0]   req_be_i,
  input  logic [`PERIPH_DATA_W-1:0] req_wdata_i,

  output logic                      rsp_valid_o,
  input  logic                      rsp_ready_i,
  output logic [`PERIPH_DATA_W-1:0] rsp_rdata_o,
  output logic                      rsp_err_o,

  input  logic [`GPI_W-1:0]         gp_i,
  output logic [`GPO_W-1:0]         gp_o,
  output logic                      timer_irq_o
);

  logic                 accept;
  logic                 slot_free;
  periph_pkg::dev_sel_e dev_sel;

  dev_bus_if ram_bus ();
  dev_bus_if gpio_bus ();
  dev_bus_if timer_bus ();

  bus_decoder u_bus_decoder (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .req_we_i   (req_we_i),
    .req_addr_i (req_addr_i),
    .req_wdata_i(req_wdata_i),
    .req_be_i   (req_be_i),
    .slot_free_i(slot_free),
    .accept_o   (accept),
    .sel_o      (dev_sel),
    .ram_bus    (ram_bus),
    .gpio_bus   (gpio_bus),
    .timer_bus  (timer_bus)
  );

  ram_dev u_ram (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .bus       (ram_bus)
  );

  gpio_dev u_gpio (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .bus       (gpio_bus),
    .gp_i      (gp_i),
    .gp_o      (gp_o)
  );

  timer_dev u_timer (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .bus       (timer_bus),
    .irq_o     (timer_irq_o)
  );

  rsp_mux u_rsp_mux (
    .clk_sys_i    (clk_sys_i),
    .rst_sys_ni   (rst_sys_ni),
    .accept_i     (accept),
    .sel_i        (dev_sel),
    .ram_rdata_i  (ram_bus.rdata),
    .gpio_rdata_i (gpio_bus.rdata),
    .timer_rdata_i(timer_bus.rdata),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_err_o    (rsp_err_o),
    .rsp_rdata_o  (rsp_rdata_o),
    .slot_free_o  (slot_free)
  );

endmodule

`default_nettype wire

/* ram_dev.sv */
/*
 * Word RAM with byte-enable writes and a registered one-cycle read
 */
`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module ram_dev (
  input  logic       clk_sys_i,
  input  logic       rst_sys_ni,
  dev_bus_if.device  bus
);

  localparam int WidxW = $clog2(`RAM_WORDS);

  logic [`PERIPH_DATA_W-1:0] mem [`RAM_WORDS];
  logic [WidxW-1:0]          widx;
  logic                      wr;
  logic                      rd;

  assign widx = bus.offset[2 +: WidxW]; // Drop the byte lane bits
  assign wr   = bus.req && (bus.op == periph_pkg::OpWrite);
  assign rd   = bus.req && (bus.op == periph_pkg::OpRead);

  always_ff @(posedge clk_sys_i) begin
    if (wr) begin
      for (int b = 0; b < `PERIPH_BE_W; b++) begin
        if (bus.be[b]) begin
          mem[widx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read data holds between reads
  always_ff @(posedge clk_sys_i) begin
    if (rd) begin
      bus.rdata <= mem[widx];
    end
  end

  // Decoder only hands over aligned offsets that land in the array
  a_ofs_in_range: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    bus.req |-> (bus.offset[1:0] == 2'b00) && ((bus.offset >> 2) < `RAM_WORDS));

endmodule

`default_nettype wire

/* rsp_mux.sv */
/*
 * One-entry response slot: read data select, error for unmapped accesses,
 * hold under back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module rsp_mux (
  input  logic                      clk_sys_i,
  input  logic                      rst_sys_ni,

  input  logic                      accept_i,
  input  periph_pkg::dev_sel_e      sel_i,
  input  logic [`PERIPH_DATA_W-1:0] ram_rdata_i,
  input  logic [`PERIPH_DATA_W-1:0] gpio_rdata_i,
  input  logic [`PERIPH_DATA_W-1:0] timer_rdata_i,

  input  logic                      rsp_ready_i,
  output logic                      rsp_valid_o,
  output logic                      rsp_err_o,
  output logic [`PERIPH_DATA_W-1:0] rsp_rdata_o,
  output logic                      slot_free_o
);

  logic                 valid_q;
  logic                 err_q;
  periph_pkg::dev_sel_e sel_q;

  // Free when empty or drained this cycle
  assign slot_free_o = !valid_q || rsp_ready_i;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
      sel_q   <= periph_pkg::DevNone;
    end else if (accept_i) begin
      valid_q <= 1'b1;
      err_q   <= sel_i == periph_pkg::DevNone;
      sel_q   <= sel_i;
    end else if (rsp_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Device rdata is stable while the slot is held
  always_comb begin
    case (sel_q)
      periph_pkg::DevRam:   rsp_rdata_o = ram_rdata_i;
      periph_pkg::DevGpio:  rsp_rdata_o = gpio_rdata_i;
      periph_pkg::DevTimer: rsp_rdata_o = timer_rdata_i;
      default:              rsp_rdata_o = '0;
    endcase
  end

  assign rsp_valid_o = valid_q;
  assign rsp_err_o   = err_q;

  a_rsp_stable: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    rsp_valid_o && !rsp_ready_i |=>
      rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_err_o));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build the peripheral testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_periph -f sim.f -o tb_periph
./obj_dir/tb_periph > sim.log 2>&1 || true
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* sim.f */
+incdir+.
periph_pkg.sv
dev_bus_if.sv
bus_decoder.sv
ram_dev.sv
gpio_dev.sv
timer_dev.sv
rsp_mux.sv
periph_top.sv
tb_periph.sv

/* tb_periph.sv */
/*
 * Testbench for the peripheral subsystem: RAM traffic under back-pressure,
 * GPIO, address map errors and the timer interrupt
 */
`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module tb_periph;

  localparam int TIMEOUT  = 2000; // Cycles per wait
  localparam int OWN_RAM  = 0;
  localparam int OWN_GPIO = 1;
  localparam int OWN_TMR  = 2;
  localparam int OWN_NONE = 3;

  logic                      clk_sys_i;
  logic                      rst_sys_ni;
  logic                      req_valid_i;
  logic                      req_ready_o;
  logic                      req_we_i;
  logic [`PERIPH_ADDR_W-1:0] req_addr_i;
  logic [`PERIPH_BE_W-1:0]   req_be_i;
  logic [`PERIPH_DATA_W-1:0] req_wdata_i;
  logic                      rsp_valid_o;
  logic                      rsp_ready_i;
  logic [`PERIPH_DATA_W-1:0] rsp_rdata_o;
  logic                      rsp_err_o;
  logic [`GPI_W-1:0]         gp_i;
  logic [`GPO_W-1:0]         gp_o;
  logic                      timer_irq_o;

  // Reference state
  logic [31:0]       ram_model [`RAM_WORDS];
  logic [`GPO_W-1:0] gpo_model;
  logic [`GPI_W-1:0] gpi_model;
  int                err_count;
  int                n_req;
  int                n_rsp;

  // Expected responses, oldest first
  logic [31:0] exp_data [$];
  logic        exp_err [$];
  logic        exp_chk [$];  // Data compared
  logic        exp_tmr [$];  // Timer read, value kept for later
  string       exp_name [$];
  logic [31:0] timer_vals [$];

  periph_top dut (.*);

  initial begin
    clk_sys_i = 1'b0;
    forever #50 clk_sys_i = ~clk_sys_i;
  end

  initial begin
    rsp_ready_i <= 1'b0;
    forever begin
      @(posedge clk_sys_i);
      rsp_ready_i <= ($urandom % 4) != 0; // Low about one cycle in four
    end
  end

  function automatic int addr_owner(input logic [31:0] addr);
    if (addr[1:0] != 2'b00) return OWN_NONE;
    if ((addr & `RAM_MASK) == `RAM_BASE) return OWN_RAM;
    if ((addr & `GPIO_MASK) == `GPIO_BASE) return OWN_GPIO;
    if ((addr & `TIMER_MASK) == `TIMER_BASE) return OWN_TMR;
    return OWN_NONE;
  endfunction

  // Returns {err, rdata} and updates the model on writes
  function automatic logic [32:0] ref_access(input logic we, input logic [31:0] addr,
                                             input logic [3:0] be, input logic [31:0] wdata);
    int          owner;
    logic [31:0] rd;
    owner = addr_owner(addr);
    rd    = '0;
    if (owner == OWN_NONE) begin
      return {1'b1, 32'h0};
    end else if (owner == OWN_RAM) begin
      for (int b = 0; b < 4; b++) begin
        if (we && be[b]) ram_model[addr[11:2]][8*b +: 8] = wdata[8*b +: 8];
      end
      rd = ram_model[addr[11:2]];
    end else if (owner == OWN_GPIO) begin
      if (addr[11:0] == `GPIO_OUT_OFS) begin
        for (int b = 0; b < 2; b++) begin
          if (we && be[b]) gpo_model[8*b +: 8] = wdata[8*b +: 8];
        end
        rd = 32'(gpo_model);
      end else if (addr[11:0] == `GPIO_IN_OFS) begin
        rd = 32'(gpi_model);
      end
    end
    return {1'b0, rd}; // Timer data is not predicted
  endfunction

  function automatic logic [31:0] ram_word_addr(input int idx);
    return `RAM_BASE + (32'(idx) << 2);
  endfunction

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Finished with errors");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      err_count++;
    end
  endtask

  // Called at a rising edge, returns at the edge that transfers the request
  task automatic send_req(input string name, input logic we, input logic [31:0] addr,
                          input logic [3:0] be, input logic [31:0] wdata);
    logic [32:0] res;
    int          owner;
    int          waited;
    owner       = addr_owner(addr);
    res         = ref_access(we, addr, be, wdata);
    req_valid_i <= 1'b1;
    req_we_i    <= we;
    req_addr_i  <= addr;
    req_be_i    <= be;
    req_wdata_i <= wdata;
    waited = 0;
    do begin
      @(negedge clk_sys_i);
      waited++;
      if (waited > TIMEOUT) stop_on_timeout("req_ready_o");
    end while (!req_ready_o);
    exp_data.push_back(res[31:0]);
    exp_err.push_back(res[32]);
    exp_chk.push_back(res[32] || (!we && owner != OWN_TMR));
    exp_tmr.push_back(!res[32] && !we && owner == OWN_TMR);
    exp_name.push_back(name);
    n_req++;
    @(posedge clk_sys_i);
  endtask

  task automatic go_idle();
    req_valid_i <= 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_data.size() != 0) begin
      @(negedge clk_sys_i);
      waited++;
      if (waited > TIMEOUT) stop_on_timeout("outstanding responses");
    end
    @(posedge clk_sys_i);
  endtask

  task automatic wait_irq(input logic level);
    int waited;
    waited = 0;
    do begin
      @(negedge clk_sys_i);
      waited++;
      if (waited > TIMEOUT) stop_on_timeout("timer_irq_o");
    end while (timer_irq_o !== level);
    @(posedge clk_sys_i);
  endtask

  task automatic take_response();
    string       name;
    logic [31:0] e_data;
    logic        e_err;
    logic        e_chk;
    logic        e_tmr;
    if (exp_data.size() == 0) begin
      $display("Response arrived with no outstanding request");
      err_count++;
    end else begin
      name   = exp_name.pop_front();
      e_data = exp_data.pop_front();
      e_err  = exp_err.pop_front();
      e_chk  = exp_chk.pop_front();
      e_tmr  = exp_tmr.pop_front();
      check_value({name, " err"}, 32'(e_err), 32'(rsp_err_o));
      if (e_chk) check_value({name, " rdata"}, e_data, rsp_rdata_o);
      if (e_tmr) timer_vals.push_back(rsp_rdata_o);
      n_rsp++;
    end
  endtask

  // Compares in order and watches held responses
  initial begin : rsp_checker
    logic        hold;
    logic [31:0] held_data;
    logic        held_err;
    hold = 1'b0;
    held_data = '0;
    held_err = 1'b0;
    forever begin
      @(negedge clk_sys_i);
      if (hold && (!rsp_valid_o || rsp_rdata_o !== held_data || rsp_err_o !== held_err)) begin
        $display("Response changed while rsp_ready_i was low");
        err_count++;
      end
      hold = 1'b0;
      if (rst_sys_ni && rsp_valid_o) begin
        if (rsp_ready_i) begin
          take_response();
        end else begin
          hold      = 1'b1;
          held_data = rsp_rdata_o;
          held_err  = rsp_err_o;
        end
      end
    end
  end

  initial begin : main_seq
    int unsigned seed_ret;
    int          idx [16];
    int          k;
    seed_ret = $urandom(32'h261e736b);
    err_count = 0;
    n_req = 0;
    n_rsp = 0;
    gpo_model = '0;
    gpi_model = '0;
    rst_sys_ni  <= 1'b0;
    req_valid_i <= 1'b0;
    req_we_i    <= 1'b0;
    req_addr_i  <= '0;
    req_be_i    <= '0;
    req_wdata_i <= '0;
    gp_i        <= '0;
    repeat (16) @(posedge clk_sys_i);
    rst_sys_ni <= 1'b1;
    @(negedge clk_sys_i);
    if (timer_irq_o !== 1'b0) begin
      $display("FAIL timer_reset: expected 0, actual %b", timer_irq_o);
      err_count++;
    end
    @(posedge clk_sys_i);

    // RAM: full writes, byte-enable merges, read back
    for (int i = 0; i < 16; i++) begin
      idx[i] = $urandom % `RAM_WORDS;
      send_req("ram_init", 1'b1, ram_word_addr(idx[i]), 4'hF, $urandom);
    end
    for (int i = 0; i < 32; i++) begin
      k = $urandom % 16;
      send_req("ram_bytewr", 1'b1, ram_word_addr(idx[k]), 4'($urandom), $urandom);
    end
    for (int i = 0; i < 16; i++) send_req("ram_read", 1'b0, ram_word_addr(idx[i]), 4'hF, '0);
    go_idle();
    wait_drained();

    // GPIO
    send_req("gpo_write", 1'b1, `GPIO_BASE + 32'(`GPIO_OUT_OFS), 4'hF, 32'h1234_ABCD);
    go_idle();
    wait_drained();
    @(negedge clk_sys_i);
    check_value("gpo_pins", 32'(gpo_model), 32'(gp_o));
    @(posedge clk_sys_i);
    send_req("gpo_read", 1'b0, `GPIO_BASE + 32'(`GPIO_OUT_OFS), 4'hF, '0);
    send_req("gpo_byte", 1'b1, `GPIO_BASE + 32'(`GPIO_OUT_OFS), 4'b0010, 32'h0000_7700);
    send_req("gpo_read2", 1'b0, `GPIO_BASE + 32'(`GPIO_OUT_OFS), 4'hF, '0);
    gp_i <= 8'hA5;
    gpi_model = 8'hA5;
    go_idle();
    repeat (4) @(posedge clk_sys_i); // Past the two-flop synchronizer
    send_req("gpi_read", 1'b0, `GPIO_BASE + 32'(`GPIO_IN_OFS), 4'hF, '0);
    send_req("gpio_unused", 1'b0, `GPIO_BASE + 32'h8, 4'hF, '0);

    // Unmapped and misaligned, RAM word must survive
    send_req("unmapped_rd", 1'b0, 32'h4000_0000, 4'hF, '0);
    send_req("unmapped_wr", 1'b1, 32'h8000_1000, 4'hF, 32'hDEAD_BEEF);
    send_req("misalign_wr", 1'b1, ram_word_addr(idx[0]) + 32'd1, 4'hF, 32'hCAFE_F00D);
    send_req("misalign_rd", 1'b0, ram_word_addr(idx[0]) + 32'd2, 4'hF, '0);
    send_req("ram_intact", 1'b0, ram_word_addr(idx[0]), 4'hF, '0);
    go_idle();
    wait_drained();

    // Timer
    send_req("time_rd0", 1'b0, `TIMER_BASE + 32'(`TIMER_TIME_LO_OFS), 4'hF, '0);
    go_idle();
    wait_drained();
    send_req("time_rd1", 1'b0, `TIMER_BASE + 32'(`TIMER_TIME_LO_OFS), 4'hF, '0);
    go_idle();
    wait_drained();
    if (timer_vals.size() != 2) begin
      $display("Timer reads did not return two values");
      err_count++;
    end else if (!(timer_vals[1] > timer_vals[0])) begin
      $display("FAIL time_incr: expected above %h, actual %h", timer_vals[0], timer_vals[1]);
      err_count++;
    end
    send_req("cmp_lo_small", 1'b1, `TIMER_BASE + 32'(`TIMER_CMP_LO_OFS), 4'hF, 32'h40);
    send_req("cmp_hi_small", 1'b1, `TIMER_BASE + 32'(`TIMER_CMP_HI_OFS), 4'hF, 32'h0);
    go_idle();
    wait_irq(1'b1);
    send_req("cmp_lo_max", 1'b1, `TIMER_BASE + 32'(`TIMER_CMP_LO_OFS), 4'hF, 32'hFFFF_FFFF);
    send_req("cmp_hi_max", 1'b1, `TIMER_BASE + 32'(`TIMER_CMP_HI_OFS), 4'hF, 32'hFFFF_FFFF);
    go_idle();
    wait_irq(1'b0);

    // Back-to-back mixed RAM traffic
    for (int i = 0; i < 40; i++) begin
      k = $urandom % 16;
      send_req("ram_mixed", 1'($urandom), ram_word_addr(idx[k]), 4'($urandom), $urandom);
    end
    go_idle();
    wait_drained();

    if (n_req != n_rsp) begin
      $display("Request and response counts differ");
      err_count++;
    end
    $display("Errors: %0d, requests: %0d, responses: %0d", err_count, n_req, n_rsp);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* timer_dev.sv */
/*
 * Machine timer: 64-bit free-running time, 64-bit compare, registered irq
 */
`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module timer_dev (
  input  logic      clk_sys_i,
  input  logic      rst_sys_ni,
  dev_bus_if.device bus,
  output logic      irq_o
);

  logic [63:0] time_q;
  logic [63:0] cmp_q;
  logic        wr;

  assign wr = bus.req && (bus.op == periph_pkg::OpWrite);

  // Bus writes land after the increment so they win
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      time_q <= '0;
      cmp_q  <= '1; // Parked out of reach
      irq_o  <= 1'b0;
    end else begin
      time_q <= time_q + 64'd1;
      irq_o  <= time_q >= cmp_q;
      if (wr) begin
        for (int b = 0; b < `PERIPH_BE_W; b++) begin
          if (bus.be[b]) begin
            case (bus.offset)
              `TIMER_TIME_LO_OFS: time_q[8*b +: 8]      <= bus.wdata[8*b +: 8];
              `TIMER_TIME_HI_OFS: time_q[32 + 8*b +: 8] <= bus.wdata[8*b +: 8];
              `TIMER_CMP_LO_OFS:  cmp_q[8*b +: 8]       <= bus.wdata[8*b +: 8];
              `TIMER_CMP_HI_OFS:  cmp_q[32 + 8*b +: 8]  <= bus.wdata[8*b +: 8];
              default: ;
            endcase
          end
        end
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (bus.req && (bus.op == periph_pkg::OpRead)) begin
      case (bus.offset)
        `TIMER_TIME_LO_OFS: bus.rdata <= time_q[31:0];
        `TIMER_TIME_HI_OFS: bus.rdata <= time_q[63:32];
        `TIMER_CMP_LO_OFS:  bus.rdata <= cmp_q[31:0];
        `TIMER_CMP_HI_OFS:  bus.rdata <= cmp_q[63:32];
        default:            bus.rdata <= '0;
      endcase
    end
  end

  // Compare resets high, so irq stays quiet for the first cycles
  a_irq_low_after_reset: assert property (@(posedge clk_sys_i)
    !rst_sys_ni |=> !irq_o [*2]);

endmodule

`default_nettype wire
